/* Makefile */
TOP := csr_unit_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(wildcard src/*.sv test/*.sv)
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* all.f */
src/gpu_core_pkg.sv
src/csr_map_pkg.sv
src/fcsr_file.sv
src/machine_csr_regs.sv
src/csr_read_mux.sv
src/csr_unit.sv
test/csr_unit_assert.sv
test/csr_unit_tb.sv

/* src/csr_map_pkg.sv */
`default_nettype none
// ################################################
// CSR address map and floating-point status fields.
// A counter's high half sits at its low address plus
// 0x80. Only 32-bit XLEN is covered.
// ################################################

package csr_map_pkg;

    localparam int unsigned CSR_ADDR_BITS = 12;

    // Floating-point status
    localparam int unsigned FFLAGS_BITS = 5;
    localparam int unsigned FRM_BITS    = 3;

    localparam logic [CSR_ADDR_BITS-1:0] CSR_FFLAGS = 12'h001;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_FRM    = 12'h002;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_FCSR   = 12'h003;

    // Machine registers that read as zero
    localparam logic [CSR_ADDR_BITS-1:0] CSR_SATP    = 12'h180;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MIE     = 12'h304;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MTVEC   = 12'h305;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MEPC    = 12'h341;

    localparam logic [CSR_ADDR_BITS-1:0] CSR_MISA     = 12'h301;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MSCRATCH = 12'h340;

    // Counters
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MCYCLE     = 12'hB00;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MINSTRET   = 12'hB02;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MCYCLE_H   = CSR_MCYCLE + 12'h080;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MINSTRET_H = CSR_MINSTRET + 12'h080;

    // Core-specific read-only registers
    localparam logic [CSR_ADDR_BITS-1:0] CSR_WARP_ID        = 12'hCC1;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_CORE_ID        = 12'hCC2;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ACTIVE_WARPS   = 12'hCC3;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ACTIVE_THREADS = 12'hCC4;

    localparam logic [CSR_ADDR_BITS-1:0] CSR_MVENDORID      = 12'hF11;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MARCHID        = 12'hF12;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MIMPID         = 12'hF13;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_NUM_THREADS    = 12'hFC0;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_NUM_WARPS      = 12'hFC1;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_NUM_CORES      = 12'hFC2;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_LOCAL_MEM_BASE = 12'hFC3;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_NUM_BARRIERS   = 12'hFC4;

endpackage

`default_nettype wire

/* src/csr_read_mux.sv */
`default_nettype none
`timescale 1ns/10ps
// ################################################
// Combinational CSR read decode, zero latency.
// Read-write CSRs appear on read_data_rw, all others
// on read_data_ro. Undecoded addresses read as zero.
// ################################################

module csr_read_mux (
    input  wire [csr_map_pkg::CSR_ADDR_BITS-1:0]     read_addr,
    input  wire [gpu_core_pkg::NW_WIDTH-1:0]         read_wid,

    input  wire [gpu_core_pkg::NUM_WARPS-1:0]
                [csr_map_pkg::FRM_BITS+csr_map_pkg::FFLAGS_BITS-1:0]
                                                     fcsr_words,
    input  wire [gpu_core_pkg::XLEN-1:0]             mscratch,
    input  wire [63:0]                               cycles,
    input  wire [63:0]                               instret,

    input  wire [gpu_core_pkg::NUM_WARPS-1:0]        active_warps,
    input  wire [gpu_core_pkg::NUM_WARPS-1:0][gpu_core_pkg::NUM_THREADS-1:0]
                                                     thread_masks,

    output wire [gpu_core_pkg::XLEN-1:0]             read_data_ro,
    output wire [gpu_core_pkg::XLEN-1:0]             read_data_rw
);

    import gpu_core_pkg::*;
    import csr_map_pkg::*;

    logic [XLEN-1:0]                 ro_data;
    logic [XLEN-1:0]                 rw_data;
    logic [FRM_BITS+FFLAGS_BITS-1:0] warp_fcsr;

    assign warp_fcsr = fcsr_words[read_wid];

    always_comb begin
        ro_data = '0;
        rw_data = '0;
        case (read_addr)
            // Read-write group
            CSR_FFLAGS: begin
                rw_data = XLEN'(warp_fcsr[FFLAGS_BITS-1:0]);
            end
            CSR_FRM: begin
                rw_data = XLEN'(warp_fcsr[FRM_BITS+FFLAGS_BITS-1:FFLAGS_BITS]);
            end
            CSR_FCSR: begin
                rw_data = XLEN'(warp_fcsr);
            end
            CSR_MSCRATCH: begin
                rw_data = mscratch;
            end

            // Identity
            CSR_MVENDORID: begin
                ro_data = VENDOR_ID;
            end
            CSR_MARCHID: begin
                ro_data = ARCHITECTURE_ID;
            end
            CSR_MIMPID: begin
                ro_data = IMPLEMENTATION_ID;
            end
            CSR_MISA: begin
                ro_data = MISA_VALUE;
            end

            // Geometry and masks
            CSR_WARP_ID: begin
                ro_data = XLEN'(read_wid);
            end
            CSR_CORE_ID: begin
                ro_data = XLEN'(CORE_ID);
            end
            CSR_ACTIVE_THREADS: begin
                ro_data = XLEN'(thread_masks[read_wid]);
            end
            CSR_ACTIVE_WARPS: begin
                ro_data = XLEN'(active_warps);
            end
            CSR_NUM_THREADS: begin
                ro_data = XLEN'(NUM_THREADS);
            end
            CSR_NUM_WARPS: begin
                ro_data = XLEN'(NUM_WARPS);
            end
            CSR_NUM_CORES: begin
                ro_data = XLEN'(NUM_CORES);
            end
            CSR_LOCAL_MEM_BASE: begin
                ro_data = LMEM_BASE_ADDR;
            end
            CSR_NUM_BARRIERS: begin
                ro_data = XLEN'(NUM_BARRIERS);
            end

            // 64-bit counters split into halves
            CSR_MCYCLE: begin
                ro_data = cycles[31:0];
            end
            CSR_MCYCLE_H: begin
                ro_data = cycles[63:32];
            end
            CSR_MINSTRET: begin
                ro_data = instret[31:0];
            end
            CSR_MINSTRET_H: begin
                ro_data = instret[63:32];
            end

            // Decoded, but always zero
            CSR_SATP, CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MEPC: begin
                ro_data = '0;
            end

            default: begin
            end
        endcase
    end

    assign read_data_ro = ro_data;
    assign read_data_rw = rw_data;

endmodule

`default_nettype wire

/* src/csr_unit.sv */
`default_nettype none
`timescale 1ns/10ps
// ################################################
// CSR block of one shader core. Plain strobes, no
// handshake; reads are combinational and writes
// show from the next cycle on.
// ################################################

module csr_unit (
    input  wire                                      clk,
    input  wire                                      reset,

    input  wire [gpu_core_pkg::XLEN-1:0]             startup_arg,
    input  wire                                      retire,

    input  wire                                      write_enable,
    input  wire [gpu_core_pkg::NW_WIDTH-1:0]         write_wid,
    input  wire [csr_map_pkg::CSR_ADDR_BITS-1:0]     write_addr,
    input  wire [gpu_core_pkg::XLEN-1:0]             write_data,

    input  wire [gpu_core_pkg::NUM_FPU_BLOCKS-1:0]   fpu_flags_valid,
    input  wire [gpu_core_pkg::NUM_FPU_BLOCKS-1:0][gpu_core_pkg::NW_WIDTH-1:0]
                                                     fpu_flags_wid,
    input  wire [gpu_core_pkg::NUM_FPU_BLOCKS-1:0][csr_map_pkg::FFLAGS_BITS-1:0]
                                                     fpu_flags,
    input  wire [gpu_core_pkg::NUM_FPU_BLOCKS-1:0][gpu_core_pkg::NW_WIDTH-1:0]
                                                     frm_read_wid,
    output wire [gpu_core_pkg::NUM_FPU_BLOCKS-1:0][csr_map_pkg::FRM_BITS-1:0]
                                                     frm_read_data,

    input  wire [csr_map_pkg::CSR_ADDR_BITS-1:0]     read_addr,
    input  wire [gpu_core_pkg::NW_WIDTH-1:0]         read_wid,
    input  wire [gpu_core_pkg::NUM_WARPS-1:0]        active_warps,
    input  wire [gpu_core_pkg::NUM_WARPS-1:0][gpu_core_pkg::NUM_THREADS-1:0]
                                                     thread_masks,
    output wire [gpu_core_pkg::XLEN-1:0]             read_data_ro,
    output wire [gpu_core_pkg::XLEN-1:0]             read_data_rw
);

    import gpu_core_pkg::*;
    import csr_map_pkg::*;

    wire [NUM_WARPS-1:0][FRM_BITS+FFLAGS_BITS-1:0] fcsr_words;
    wire [XLEN-1:0]                                mscratch;
    wire [63:0]                                    cycles;
    wire [63:0]                                    instret;

    fcsr_file u_fcsr_file (
        .clk             (clk),
        .reset           (reset),
        .write_enable    (write_enable),
        .write_wid       (write_wid),
        .write_addr      (write_addr),
        .write_data      (write_data),
        .fpu_flags_valid (fpu_flags_valid),
        .fpu_flags_wid   (fpu_flags_wid),
        .fpu_flags       (fpu_flags),
        .frm_read_wid    (frm_read_wid),
        .frm_read_data   (frm_read_data),
        .fcsr_words      (fcsr_words)
    );

    machine_csr_regs u_machine_csr_regs (
        .clk          (clk),
        .reset        (reset),
        .startup_arg  (startup_arg),
        .retire       (retire),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .mscratch     (mscratch),
        .cycles       (cycles),
        .instret      (instret)
    );

    csr_read_mux u_csr_read_mux (
        .read_addr    (read_addr),
        .read_wid     (read_wid),
        .fcsr_words   (fcsr_words),
        .mscratch     (mscratch),
        .cycles       (cycles),
        .instret      (instret),
        .active_warps (active_warps),
        .thread_masks (thread_masks),
        .read_data_ro (read_data_ro),
        .read_data_rw (read_data_rw)
    );

endmodule

`default_nettype wire

/* src/fcsr_file.sv */
`default_nettype none
`timescale 1ns/10ps
// ################################################
// Per-warp fcsr words, packed as {frm, fflags}.
// A software write to FFLAGS or FCSR overrides FPU
// accrual in the same cycle; FRM writes do not.
// ################################################

module fcsr_file (
    input  wire                                      clk,
    input  wire                                      reset,

    input  wire                                      write_enable,
    input  wire [gpu_core_pkg::NW_WIDTH-1:0]         write_wid,
    input  wire [csr_map_pkg::CSR_ADDR_BITS-1:0]     write_addr,
    input  wire [gpu_core_pkg::XLEN-1:0]             write_data,

    input  wire [gpu_core_pkg::NUM_FPU_BLOCKS-1:0]   fpu_flags_valid,
    input  wire [gpu_core_pkg::NUM_FPU_BLOCKS-1:0][gpu_core_pkg::NW_WIDTH-1:0]
                                                     fpu_flags_wid,
    input  wire [gpu_core_pkg::NUM_FPU_BLOCKS-1:0][csr_map_pkg::FFLAGS_BITS-1:0]
                                                     fpu_flags,

    input  wire [gpu_core_pkg::NUM_FPU_BLOCKS-1:0][gpu_core_pkg::NW_WIDTH-1:0]
                                                     frm_read_wid,
    output wire [gpu_core_pkg::NUM_FPU_BLOCKS-1:0][csr_map_pkg::FRM_BITS-1:0]
                                                     frm_read_data,

    output wire [gpu_core_pkg::NUM_WARPS-1:0]
                [csr_map_pkg::FRM_BITS+csr_map_pkg::FFLAGS_BITS-1:0]
                                                     fcsr_words
);

    import gpu_core_pkg::*;
    import csr_map_pkg::*;

    logic [NUM_WARPS-1:0][FRM_BITS+FFLAGS_BITS-1:0] fcsr_q;
    logic [NUM_WARPS-1:0][FRM_BITS+FFLAGS_BITS-1:0] fcsr_next;

    always_comb begin
        fcsr_next = fcsr_q;

        // Accrue into fcsr_next so two ports hitting one warp both stick
        for (int i = 0; i < NUM_FPU_BLOCKS; i++) begin
            if (fpu_flags_valid[i]) begin
                fcsr_next[fpu_flags_wid[i]][FFLAGS_BITS-1:0] =
                    fcsr_next[fpu_flags_wid[i]][FFLAGS_BITS-1:0] | fpu_flags[i];
            end
        end

        // Software write applied last, by field
        if (write_enable) begin
            case (write_addr)
                CSR_FFLAGS: begin
                    fcsr_next[write_wid][FFLAGS_BITS-1:0] = write_data[FFLAGS_BITS-1:0];
                end
                CSR_FRM: begin
                    fcsr_next[write_wid][FRM_BITS+FFLAGS_BITS-1:FFLAGS_BITS] =
                        write_data[FRM_BITS-1:0];
                end
                CSR_FCSR: begin
                    fcsr_next[write_wid] = write_data[FRM_BITS+FFLAGS_BITS-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr_q <= '0;
        end else begin
            fcsr_q <= fcsr_next;
        end
    end

    // Rounding mode served per FPU port
    for (genvar i = 0; i < NUM_FPU_BLOCKS; i++) begin : g_frm_read
        assign frm_read_data[i] = fcsr_q[frm_read_wid[i]][FRM_BITS+FFLAGS_BITS-1:FFLAGS_BITS];
    end

    assign fcsr_words = fcsr_q;

endmodule

`default_nettype wire

/* src/gpu_core_pkg.sv */
`default_nettype none
// ################################################
// Geometry and identity of one shader core. Warp
// numbers are at least one bit wide, also with a
// single warp. Constants are read back through CSRs.
// ################################################

package gpu_core_pkg;

    // Core geometry
    localparam int unsigned NUM_WARPS      = 4;
    localparam int unsigned NUM_THREADS    = 4;
    localparam int unsigned NW_WIDTH       = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;
    localparam int unsigned NUM_FPU_BLOCKS = 2;
    localparam int unsigned XLEN           = 32;

    localparam int unsigned CORE_ID        = 0;
    localparam int unsigned NUM_CORES      = 1;
    localparam int unsigned NUM_BARRIERS   = 4;
    localparam logic [XLEN-1:0] LMEM_BASE_ADDR = 32'h0000_8000;

    // Identity
    localparam logic [XLEN-1:0] VENDOR_ID         = 32'h0000_0000;
    localparam logic [XLEN-1:0] ARCHITECTURE_ID   = 32'h0000_0001;
    localparam logic [XLEN-1:0] IMPLEMENTATION_ID = 32'h0000_0001;

    // MXL=1 (RV32), extensions F, I and M
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_1120;

endpackage

`default_nettype wire

/* src/machine_csr_regs.sv */
`default_nettype none
`timescale 1ns/10ps
// ################################################
// mscratch plus the 64-bit cycle and instret
// counters. Counters are zero in the first cycle
// after reset and have no write path.
// ################################################

module machine_csr_regs (
    input  wire                                  clk,
    input  wire                                  reset,

    input  wire [gpu_core_pkg::XLEN-1:0]         startup_arg,
    input  wire                                  retire,

    input  wire                                  write_enable,
    input  wire [csr_map_pkg::CSR_ADDR_BITS-1:0] write_addr,
    input  wire [gpu_core_pkg::XLEN-1:0]         write_data,

    output wire [gpu_core_pkg::XLEN-1:0]         mscratch,
    output wire [63:0]                           cycles,
    output wire [63:0]                           instret
);

    import gpu_core_pkg::*;
    import csr_map_pkg::*;

    logic [XLEN-1:0] mscratch_q;
    logic [63:0]     cycles_q;
    logic [63:0]     instret_q;
    logic            mscratch_we;

    assign mscratch_we = write_enable && (write_addr == CSR_MSCRATCH);

    // Startup argument handed to software through mscratch
    always_ff @(posedge clk) begin
        if (reset) begin
            mscratch_q <= startup_arg;
        end else if (mscratch_we) begin
            mscratch_q <= write_data;
        end
    end

    // Free-running cycle count
    always_ff @(posedge clk) begin
        if (reset) begin
            cycles_q <= '0;
        end else begin
            cycles_q <= cycles_q + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instret_q <= '0;
        end else if (retire) begin
            instret_q <= instret_q + 64'd1;
        end
    end

    assign mscratch = mscratch_q;
    assign cycles   = cycles_q;
    assign instret  = instret_q;

endmodule

`default_nettype wire

/* test/csr_unit_assert.sv */
`default_nettype none
`timescale 1ns/10ps
// ################################################
// Counter checks bound into csr_unit. All checks
// are off in reset; counter reads assume one read
// address per cycle, stable at the rising edge.
// ################################################

module csr_unit_assert (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  retire,
    input  wire [csr_map_pkg::CSR_ADDR_BITS-1:0] read_addr,
    input  wire [gpu_core_pkg::XLEN-1:0]         read_data_ro,
    input  wire [gpu_core_pkg::XLEN-1:0]         read_data_rw,
    input  wire [63:0]                           cycles,
    input  wire [63:0]                           instret
);

    import gpu_core_pkg::*;
    import csr_map_pkg::*;

    int fail_count = 0;

    // First cycle out of reset starts the count at zero
    a_cycles_start: assert property (@(posedge clk) disable iff (reset)
            $past(reset) |-> (cycles == 64'd0))
        else begin
            fail_count++;
            $error("cycle counter not zero in the first cycle after reset");
        end

    a_cycles_step: assert property (@(posedge clk) disable iff (reset)
            !$past(reset) |-> (cycles == $past(cycles) + 64'd1))
        else begin
            fail_count++;
            $error("cycle counter did not advance by one");
        end

    a_instret_step: assert property (@(posedge clk) disable iff (reset)
            !$past(reset) |-> (instret == $past(instret) + 64'($past(retire))))
        else begin
            fail_count++;
            $error("instret did not follow the retire pulses");
        end

    // Counter halves as seen on the read port
    a_mcycle_read: assert property (@(posedge clk) disable iff (reset)
            ((read_addr == CSR_MCYCLE) && !$past(reset)) |->
            ((read_data_ro == $past(cycles[31:0]) + 32'd1) && (read_data_rw == '0)))
        else begin
            fail_count++;
            $error("MCYCLE read is not the previous count plus one");
        end

    a_mcycle_h_read: assert property (@(posedge clk) disable iff (reset)
            ((read_addr == CSR_MCYCLE_H) && !$past(reset)) |->
            ((read_data_ro == 32'(($past(cycles) + 64'd1) >> 32)) && (read_data_rw == '0)))
        else begin
            fail_count++;
            $error("MCYCLE_H read is not the upper half of the previous count plus one");
        end

    a_minstret_read: assert property (@(posedge clk) disable iff (reset)
            (((read_addr == CSR_MINSTRET) || (read_addr == CSR_MINSTRET_H)) && !$past(reset))
            |->
            ((read_data_ro == ((read_addr == CSR_MINSTRET) ?
                               32'($past(instret) + 64'($past(retire))) :
                               32'(($past(instret) + 64'($past(retire))) >> 32)))
             && (read_data_rw == '0)))
        else begin
            fail_count++;
            $error("MINSTRET read does not match the retired count");
        end

endmodule

bind csr_unit csr_unit_assert u_csr_unit_assert (
    .clk          (clk),
    .reset        (reset),
    .retire       (retire),
    .read_addr    (read_addr),
    .read_data_ro (read_data_ro),
    .read_data_rw (read_data_rw),
    .cycles       (cycles),
    .instret      (instret)
);

`default_nettype wire

/* test/csr_unit_tb.sv */
`default_nettype none
`timescale 1ns/10ps
// ################################################
// Random stimulus with a mirror of the writable CSR
// state. Inputs change on the falling edge, reads
// are compared there. Counter timing is bound-checked.
// ################################################

module csr_unit_tb;

    import gpu_core_pkg::*;
    import csr_map_pkg::*;

    localparam int unsigned CLK_PERIOD      = 8;
    localparam int unsigned RESET_CYCLES    = 2;
    localparam int unsigned RANDOM_CYCLES   = 2000;
    localparam int unsigned WATCHDOG_CYCLES = RANDOM_CYCLES + 100;
    localparam int unsigned FW              = FRM_BITS + FFLAGS_BITS;

    logic                                       clk;
    logic                                       reset;
    logic [XLEN-1:0]                            startup_arg;
    logic                                       retire;
    logic                                       write_enable;
    logic [NW_WIDTH-1:0]                        write_wid;
    logic [CSR_ADDR_BITS-1:0]                   write_addr;
    logic [XLEN-1:0]                            write_data;
    logic [NUM_FPU_BLOCKS-1:0]                  fpu_flags_valid;
    logic [NUM_FPU_BLOCKS-1:0][NW_WIDTH-1:0]    fpu_flags_wid;
    logic [NUM_FPU_BLOCKS-1:0][FFLAGS_BITS-1:0] fpu_flags;
    logic [NUM_FPU_BLOCKS-1:0][NW_WIDTH-1:0]    frm_read_wid;
    wire  [NUM_FPU_BLOCKS-1:0][FRM_BITS-1:0]    frm_read_data;
    logic [CSR_ADDR_BITS-1:0]                   read_addr;
    logic [NW_WIDTH-1:0]                        read_wid;
    logic [NUM_WARPS-1:0]                       active_warps;
    logic [NUM_WARPS-1:0][NUM_THREADS-1:0]      thread_masks;
    wire  [XLEN-1:0]                            read_data_ro;
    wire  [XLEN-1:0]                            read_data_rw;

    // Mirror of the DUT state
    logic [FW-1:0]            fcsr_model [NUM_WARPS];
    logic [XLEN-1:0]          mscratch_model;
    logic [63:0]              cycles_model;
    logic [63:0]              instret_model;

    logic [31:0]              rng_state;
    logic [CSR_ADDR_BITS-1:0] addr_table [32];
    logic [CSR_ADDR_BITS-1:0] wr_table [4];
    int                       error_count;

    csr_unit UUT (
        .clk             (clk),
        .reset           (reset),
        .startup_arg     (startup_arg),
        .retire          (retire),
        .write_enable    (write_enable),
        .write_wid       (write_wid),
        .write_addr      (write_addr),
        .write_data      (write_data),
        .fpu_flags_valid (fpu_flags_valid),
        .fpu_flags_wid   (fpu_flags_wid),
        .fpu_flags       (fpu_flags),
        .frm_read_wid    (frm_read_wid),
        .frm_read_data   (frm_read_data),
        .read_addr       (read_addr),
        .read_wid        (read_wid),
        .active_warps    (active_warps),
        .thread_masks    (thread_masks),
        .read_data_ro    (read_data_ro),
        .read_data_rw    (read_data_rw)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // Effect of the inputs sampled at the last rising edge
    task automatic update_model;
        if (reset) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                fcsr_model[w] = '0;
            end
            mscratch_model = startup_arg;
            cycles_model   = '0;
            instret_model  = '0;
        end else begin
            cycles_model = cycles_model + 64'd1;
            if (retire) begin
                instret_model = instret_model + 64'd1;
            end
            for (int i = 0; i < NUM_FPU_BLOCKS; i++) begin
                if (fpu_flags_valid[i]) begin
                    fcsr_model[fpu_flags_wid[i]][FFLAGS_BITS-1:0] =
                        fcsr_model[fpu_flags_wid[i]][FFLAGS_BITS-1:0] | fpu_flags[i];
                end
            end
            // Software write after accrual, so FFLAGS and FCSR win
            if (write_enable) begin
                case (write_addr)
                    CSR_FFLAGS: fcsr_model[write_wid][FFLAGS_BITS-1:0] =
                        write_data[FFLAGS_BITS-1:0];
                    CSR_FRM: fcsr_model[write_wid][FW-1:FFLAGS_BITS] = write_data[FRM_BITS-1:0];
                    CSR_FCSR: fcsr_model[write_wid] = write_data[FW-1:0];
                    CSR_MSCRATCH: mscratch_model = write_data;
                    default: ;
                endcase
            end
        end
    endtask

    task automatic expected_read(input logic [CSR_ADDR_BITS-1:0] addr,
                                 input logic [NW_WIDTH-1:0] wid,
                                 output logic [XLEN-1:0] ro, output logic [XLEN-1:0] rw);
        ro = '0;
        rw = '0;
        case (addr)
            CSR_FFLAGS:         rw = XLEN'(fcsr_model[wid][FFLAGS_BITS-1:0]);
            CSR_FRM:            rw = XLEN'(fcsr_model[wid][FW-1:FFLAGS_BITS]);
            CSR_FCSR:           rw = XLEN'(fcsr_model[wid]);
            CSR_MSCRATCH:       rw = mscratch_model;
            CSR_MVENDORID:      ro = VENDOR_ID;
            CSR_MARCHID:        ro = ARCHITECTURE_ID;
            CSR_MIMPID:         ro = IMPLEMENTATION_ID;
            CSR_MISA:           ro = MISA_VALUE;
            CSR_WARP_ID:        ro = XLEN'(wid);
            CSR_CORE_ID:        ro = XLEN'(CORE_ID);
            CSR_ACTIVE_THREADS: ro = XLEN'(thread_masks[wid]);
            CSR_ACTIVE_WARPS:   ro = XLEN'(active_warps);
            CSR_NUM_THREADS:    ro = XLEN'(NUM_THREADS);
            CSR_NUM_WARPS:      ro = XLEN'(NUM_WARPS);
            CSR_NUM_CORES:      ro = XLEN'(NUM_CORES);
            CSR_LOCAL_MEM_BASE: ro = LMEM_BASE_ADDR;
            CSR_NUM_BARRIERS:   ro = XLEN'(NUM_BARRIERS);
            CSR_MCYCLE:         ro = cycles_model[31:0];
            CSR_MCYCLE_H:       ro = cycles_model[63:32];
            CSR_MINSTRET:       ro = instret_model[31:0];
            CSR_MINSTRET_H:     ro = instret_model[63:32];
            default: ;
        endcase
    endtask

    task automatic check_outputs;
        logic [XLEN-1:0] exp_ro;
        logic [XLEN-1:0] exp_rw;
        string           where;
        expected_read(read_addr, read_wid, exp_ro, exp_rw);
        where = $sformatf("csr %h wid %0d", read_addr, read_wid);
        check_value({"read_data_ro ", where}, exp_ro, read_data_ro);
        check_value({"read_data_rw ", where}, exp_rw, read_data_rw);
        for (int i = 0; i < NUM_FPU_BLOCKS; i++) begin
            check_value($sformatf("frm_read_data[%0d] wid %0d", i, frm_read_wid[i]),
                        XLEN'(fcsr_model[frm_read_wid[i]][FW-1:FFLAGS_BITS]),
                        XLEN'(frm_read_data[i]));
        end
    endtask

    task automatic next_cycle;
        @(negedge clk);
        update_model();
        check_outputs();
    endtask

    task automatic drive_random;
        logic [31:0] r;
        draw_random(r);
        read_addr    = (r[2:0] == 3'd0) ? r[31:20] : addr_table[r[7:3]];
        read_wid     = r[8 +: NW_WIDTH];
        write_wid    = r[12 +: NW_WIDTH];
        write_enable = r[16];
        retire       = r[17];
        write_addr   = r[18] ? wr_table[r[20:19]] : addr_table[r[25:21]];
        draw_random(r);
        write_data = r;
        // Sparse flags so accrued bits do not saturate at once
        draw_random(r);
        fpu_flags_valid = r[0 +: NUM_FPU_BLOCKS] & r[2 +: NUM_FPU_BLOCKS];
        fpu_flags = r[6 +: NUM_FPU_BLOCKS*FFLAGS_BITS] & r[16 +: NUM_FPU_BLOCKS*FFLAGS_BITS];
        fpu_flags_wid = r[26 +: NUM_FPU_BLOCKS*NW_WIDTH];
        draw_random(r);
        frm_read_wid = r[0 +: NUM_FPU_BLOCKS*NW_WIDTH];
        active_warps = r[8 +: NUM_WARPS];
        thread_masks = r[16 +: NUM_WARPS*NUM_THREADS];
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog: run did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        error_count     = 0;
        rng_state       = 32'h60d0;
        clk             = 1'b0;
        reset           = 1'b1;
        startup_arg     = 32'hC0DE_5A17;
        retire          = 1'b0;
        write_enable    = 1'b0;
        write_wid       = '0;
        write_addr      = '0;
        write_data      = '0;
        fpu_flags_valid = '0;
        fpu_flags_wid   = '0;
        fpu_flags       = '0;
        frm_read_wid    = '0;
        read_addr       = '0;
        read_wid        = '0;
        active_warps    = '0;
        thread_masks    = '0;
        wr_table        = '{CSR_FFLAGS, CSR_FRM, CSR_FCSR, CSR_MSCRATCH};
        addr_table      = '{
            CSR_FFLAGS, CSR_FRM, CSR_FCSR, CSR_MSCRATCH,
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MISA,
            CSR_WARP_ID, CSR_CORE_ID, CSR_ACTIVE_THREADS, CSR_ACTIVE_WARPS,
            CSR_NUM_THREADS, CSR_NUM_WARPS, CSR_NUM_CORES, CSR_LOCAL_MEM_BASE,
            CSR_NUM_BARRIERS, CSR_MCYCLE, CSR_MCYCLE_H, CSR_MINSTRET,
            CSR_MINSTRET_H, CSR_SATP, CSR_MSTATUS, CSR_MIE,
            CSR_MTVEC, CSR_MEPC, 12'h000, 12'h004,
            12'h342, 12'h7C0, 12'hC00, 12'hFFF
        };

        repeat (RESET_CYCLES) next_cycle();
        reset = 1'b0;

        // Reset values of every warp, then mscratch
        for (int w = 0; w < NUM_WARPS; w++) begin
            read_wid  = NW_WIDTH'(w);
            read_addr = CSR_FFLAGS;
            next_cycle();
            read_addr = CSR_FRM;
            next_cycle();
            read_addr = CSR_FCSR;
            next_cycle();
        end
        read_addr = CSR_MSCRATCH;
        next_cycle();

        repeat (RANDOM_CYCLES) begin
            drive_random();
            next_cycle();
        end

        $display("Error counts: %0d read mismatches, %0d assertion failures",
                 error_count, UUT.u_csr_unit_assert.fail_count);
        if (error_count == 0 && UUT.u_csr_unit_assert.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
